/* src.f */
source/region_pkg.sv
source/bus_pkg.sv
source/data_ram.sv
source/irq_encoder.sv
source/ram_port_arbiter.sv
source/lsu_router.sv
source/core_region.sv
testbench/tb_core_region.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_core_region
FILELIST  := src.f
OBJ_DIR   := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0

SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* testbench/tb_core_region.sv */
// Testbench for the core region data side. Plays the core LSU and the loader,
// models an external bus slave, and checks results against a RAM model.

`timescale 1ns/1ps
`default_nettype none

module tb_core_region
  import region_pkg::*;
  import bus_pkg::*;
();

  localparam int          N_STEPS        = 21;
  localparam int          TIMEOUT_CYCLES = N_STEPS * 8 + 50;
  localparam lsu_data_t   EXT_MASK       = 32'h5eed_0f0f;
  localparam logic [31:0] LFSR_SEED      = 32'h4f4d;
  localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;

  typedef enum logic [2:0] {LD_WR, LD_RD, CORE_WR, CORE_RD, CORE_VS_LD, IRQ} kind_e;

  // exp only holds the irq index since memory results come from the model
  typedef struct packed {
    kind_e      kind;
    lsu_addr_t  addr;
    wide_data_t data;
    wide_be_t   be;
    lsu_data_t  exp;
  } step_t;

  logic       clk, rst_n;
  logic       lsu_req_i, lsu_we_i, lsu_gnt_o, lsu_rvalid_o;
  lsu_addr_t  lsu_addr_i;
  lsu_be_t    lsu_be_i;
  lsu_data_t  lsu_wdata_i, lsu_rdata_o;
  logic       ext_req_o, ext_we_o, ext_gnt_i, ext_rvalid_i;
  lsu_addr_t  ext_addr_o;
  lsu_be_t    ext_be_o;
  lsu_data_t  ext_wdata_o, ext_rdata_i;
  logic       load_req_i, load_we_i;
  ram_addr_t  load_addr_i;
  wide_be_t   load_be_i;
  wide_data_t load_wdata_i, load_rdata_o;
  irq_vec_t   irq_i;
  logic       irq_req_o;
  irq_id_t    irq_id_o;

  step_t       steps [N_STEPS];
  wide_data_t  model [DATA_RAM_BYTES / RAM_WORD_BYTES];
  logic [31:0] lfsr_state  = LFSR_SEED;
  int          error_count = 0;
  int          cycle_count = 0;

  core_region dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  // one LFSR step per bit taken
  task automatic take_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      val = (val << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  function automatic logic is_local_addr(input lsu_addr_t addr);
    return addr[31:REGION_TAG_LSB] == LOCAL_REGION_TAG;
  endfunction

  function automatic ram_addr_t word_of(input lsu_addr_t addr);
    return ram_addr_t'(addr >> $clog2(RAM_WORD_BYTES));
  endfunction

  function automatic lsu_data_t model_half(input lsu_addr_t addr);
    wide_data_t w;
    w = model[word_of(addr)];
    return addr[2] ? w[63:32] : w[31:0];
  endfunction

  task automatic merge_bytes(input ram_addr_t word, input wide_be_t be, input wide_data_t data);
    for (int i = 0; i < RAM_WORD_BYTES; i++) begin
      if (be[i]) begin
        model[word][i*8 +: 8] = data[i*8 +: 8];
      end
    end
  endtask

  task automatic check_lsu_data(input string name, input lsu_data_t got, input lsu_data_t exp);
    if (got !== exp) begin
      $display("ERROR at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_wide_data(input string name, input wide_data_t got,
                                 input wide_data_t exp);
    if (got !== exp) begin
      $display("ERROR at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_irq_id(input string name, input irq_id_t got, input irq_id_t exp);
    if (got !== exp) begin
      $display("ERROR at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR at %0d ns: %s is %b, expected %b", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic start_core(input logic we, input lsu_addr_t addr, input lsu_be_t be,
                            input lsu_data_t wdata);
    lsu_req_i   = 1'b1;
    lsu_we_i    = we;
    lsu_addr_i  = addr;
    lsu_be_i    = be;
    lsu_wdata_i = wdata;
  endtask

  task automatic start_loader(input logic we, input ram_addr_t addr, input wide_be_t be,
                              input wide_data_t wdata);
    load_req_i   = 1'b1;
    load_we_i    = we;
    load_addr_i  = addr;
    load_be_i    = be;
    load_wdata_i = wdata;
  endtask

  // hold the request until granted, then wait for its single response
  task automatic complete_core(input logic local_acc, output lsu_data_t rdata);
    logic granted;
    granted = 1'b0;
    while (!granted) begin
      @(negedge clk);
      granted = lsu_gnt_o;
      if (!local_acc) begin
        check_flag("ext_req_o", ext_req_o, 1'b1);
        check_flag("ext_we_o", ext_we_o, lsu_we_i);
        check_lsu_data("ext_addr_o", ext_addr_o, lsu_addr_i);
        check_lsu_data("ext_be_o", lsu_data_t'(ext_be_o), lsu_data_t'(lsu_be_i));
        check_lsu_data("ext_wdata_o", ext_wdata_o, lsu_wdata_i);
      end
      next_cycle();
    end
    lsu_req_i = 1'b0;
    @(negedge clk);
    if (local_acc) begin
      check_flag("lsu_rvalid_o", lsu_rvalid_o, 1'b1);
    end
    while (!lsu_rvalid_o) begin
      next_cycle();
      @(negedge clk);
    end
    rdata = lsu_rdata_o;
    next_cycle();
  endtask

  // external slave grants after 0 to 3 cycles and answers one cycle later
  initial begin : ext_slave
    int        wait_cnt;
    logic      waiting;
    logic      rvalid_next;
    lsu_data_t resp_data;
    ext_gnt_i    = 1'b0;
    ext_rvalid_i = 1'b0;
    ext_rdata_i  = '0;
    waiting      = 1'b0;
    rvalid_next  = 1'b0;
    wait_cnt     = 0;
    resp_data    = '0;
    forever begin
      @(posedge clk);
      #2;
      ext_rvalid_i = rvalid_next;
      if (rvalid_next) begin
        ext_rdata_i = resp_data;
      end
      rvalid_next = 1'b0;
      if (ext_gnt_i) begin
        ext_gnt_i = 1'b0;
      end else if (ext_req_o) begin
        if (!waiting) begin
          take_bits(2, wait_cnt);
          waiting = 1'b1;
        end
        if (wait_cnt == 0) begin
          ext_gnt_i   = 1'b1;
          resp_data   = ext_addr_o ^ EXT_MASK;
          rvalid_next = 1'b1;
          waiting     = 1'b0;
        end else begin
          wait_cnt--;
        end
      end
    end
  end

  task automatic load_table();
    // kind, byte address, data or irq pattern, byte enables, expected irq index
    steps[0]  = '{LD_WR, 32'h0010_0000, 64'h0123_4567_89ab_cdef, 8'hff, 32'd0};
    steps[1]  = '{LD_WR, 32'h0010_0008, 64'hfedc_ba98_7654_3210, 8'hff, 32'd0};
    steps[2]  = '{LD_WR, 32'h0010_0ff8, 64'h5a5a_a5a5_3c3c_c3c3, 8'hff, 32'd0};
    steps[3]  = '{LD_RD, 32'h0010_0000, 64'h0, 8'h00, 32'd0};
    steps[4]  = '{LD_RD, 32'h0010_0ff8, 64'h0, 8'h00, 32'd0};
    steps[5]  = '{CORE_RD, 32'h0010_0008, 64'h0, 8'h0f, 32'd0};
    steps[6]  = '{CORE_RD, 32'h0010_000c, 64'h0, 8'h0f, 32'd0};
    steps[7]  = '{CORE_WR, 32'h0010_0008, 64'h1122_3344, 8'h05, 32'd0};
    steps[8]  = '{CORE_WR, 32'h0010_000c, 64'haabb_ccdd, 8'h08, 32'd0};
    steps[9]  = '{LD_RD, 32'h0010_0008, 64'h0, 8'h00, 32'd0};
    steps[10] = '{CORE_RD, 32'h0010_000c, 64'h0, 8'h0f, 32'd0};
    // outside the window with low bits aliasing RAM word 1
    steps[11] = '{CORE_WR, 32'h0200_0008, 64'hdead_beef, 8'h0f, 32'd0};
    steps[12] = '{CORE_RD, 32'h0200_0008, 64'h0, 8'h0f, 32'd0};
    steps[13] = '{CORE_RD, 32'h8000_0044, 64'h0, 8'h0f, 32'd0};
    steps[14] = '{LD_RD, 32'h0010_0008, 64'h0, 8'h00, 32'd0};
    steps[15] = '{CORE_VS_LD, 32'h0010_0004, 64'h0, 8'h0f, 32'd0};
    steps[16] = '{CORE_VS_LD, 32'h0010_0ffc, 64'h0, 8'h0f, 32'd0};
    steps[17] = '{IRQ, 32'h0, 64'h0000_0000, 8'h00, 32'd0};
    steps[18] = '{IRQ, 32'h0, 64'h0000_0001, 8'h00, 32'd0};
    steps[19] = '{IRQ, 32'h0, 64'h8000_0001, 8'h00, 32'd31};
    steps[20] = '{IRQ, 32'h0, 64'h0012_0300, 8'h00, 32'd20};
  endtask

  task automatic run_step(input step_t st);
    lsu_data_t rdata;
    ram_addr_t word;
    logic      local_acc;
    word      = word_of(st.addr);
    local_acc = is_local_addr(st.addr);
    case (st.kind)
      LD_WR: begin
        start_loader(1'b1, word, st.be, st.data);
        next_cycle();
        load_req_i = 1'b0;
        merge_bytes(word, st.be, st.data);
      end
      LD_RD: begin
        start_loader(1'b0, word, '0, '0);
        next_cycle();
        load_req_i = 1'b0;
        @(negedge clk);
        check_wide_data("load_rdata_o", load_rdata_o, model[word]);
        next_cycle();
      end
      CORE_WR, CORE_RD: begin
        start_core(st.kind == CORE_WR, st.addr, lsu_be_t'(st.be), lsu_data_t'(st.data));
        complete_core(local_acc, rdata);
        if (st.kind == CORE_WR && local_acc) begin
          merge_bytes(word, st.addr[2] ? {lsu_be_t'(st.be), 4'b0000} : {4'b0000, lsu_be_t'(st.be)},
                      {lsu_data_t'(st.data), lsu_data_t'(st.data)});
        end else if (st.kind == CORE_RD) begin
          check_lsu_data("lsu_rdata_o", rdata,
                         local_acc ? model_half(st.addr) : st.addr ^ EXT_MASK);
        end
      end
      CORE_VS_LD: begin
        // loader and core hit the RAM in the same cycle
        start_loader(1'b0, word, '0, '0);
        start_core(1'b0, st.addr, lsu_be_t'(st.be), '0);
        @(negedge clk);
        check_flag("lsu_gnt_o", lsu_gnt_o, 1'b0);
        next_cycle();
        load_req_i = 1'b0;
        check_wide_data("load_rdata_o", load_rdata_o, model[word]);
        complete_core(1'b1, rdata);
        check_lsu_data("lsu_rdata_o", rdata, model_half(st.addr));
      end
      IRQ: begin
        irq_i = irq_vec_t'(st.data);
        @(negedge clk);
        check_flag("irq_req_o", irq_req_o, |irq_i);
        check_irq_id("irq_id_o", irq_id_o, irq_id_t'(st.exp));
        next_cycle();
      end
      default: begin
        $display("step table holds an unknown kind of access");
        error_count++;
      end
    endcase
  endtask

  initial begin : watchdog
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: no end of test after %0d cycles, a handshake never finished", cycle_count);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin : main
    int errs_before;
    rst_n        = 1'b0;
    lsu_req_i    = 1'b0;
    lsu_we_i     = 1'b0;
    lsu_addr_i   = '0;
    lsu_be_i     = '0;
    lsu_wdata_i  = '0;
    load_req_i   = 1'b0;
    load_we_i    = 1'b0;
    load_addr_i  = '0;
    load_be_i    = '0;
    load_wdata_i = '0;
    irq_i        = '0;
    load_table();
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    next_cycle();
    for (int i = 0; i < N_STEPS; i++) begin
      errs_before = error_count;
      run_step(steps[i]);
      $display("step %0d %s: %s", i, steps[i].kind.name(),
               (error_count == errs_before) ? "ok" : "mismatch");
    end
    $display("%0d steps run, %0d errors", N_STEPS, error_count);
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule : tb_core_region

`default_nettype wire

/* source/core_region.sv */
// Data side of the core region: address router, RAM arbiter, data RAM and
// interrupt encoder. The load/store port is driven by the core's LSU.

`timescale 1ns/1ps
`default_nettype none

module core_region
  import region_pkg::*;
  import bus_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic       lsu_req_i,
  input  wire logic       lsu_we_i,
  input  wire lsu_addr_t  lsu_addr_i,
  input  wire lsu_be_t    lsu_be_i,
  input  wire lsu_data_t  lsu_wdata_i,
  output logic            lsu_gnt_o,
  output logic            lsu_rvalid_o,
  output lsu_data_t       lsu_rdata_o,
  output logic            ext_req_o,
  output logic            ext_we_o,
  output lsu_addr_t       ext_addr_o,
  output lsu_be_t         ext_be_o,
  output lsu_data_t       ext_wdata_o,
  input  wire logic       ext_gnt_i,
  input  wire logic       ext_rvalid_i,
  input  wire lsu_data_t  ext_rdata_i,
  input  wire logic       load_req_i,
  input  wire logic       load_we_i,
  input  wire ram_addr_t  load_addr_i,
  input  wire wide_be_t   load_be_i,
  input  wire wide_data_t load_wdata_i,
  output wide_data_t      load_rdata_o,
  input  wire irq_vec_t   irq_i,
  output logic            irq_req_o,
  output irq_id_t         irq_id_o
);

  // router to arbiter
  logic      ram_req, ram_we, ram_gnt, ram_rvalid;
  lsu_addr_t ram_addr;
  lsu_be_t   ram_be;
  lsu_data_t ram_wdata, ram_rdata;

  // arbiter to memory
  logic       en, we;
  ram_addr_t  addr;
  wide_be_t   be;
  wide_data_t wdata, rdata;

  lsu_router router0 (
    .clk, .rst_n,
    .lsu_req_i, .lsu_we_i, .lsu_addr_i, .lsu_be_i, .lsu_wdata_i,
    .lsu_gnt_o, .lsu_rvalid_o, .lsu_rdata_o,
    .ext_req_o, .ext_we_o, .ext_addr_o, .ext_be_o, .ext_wdata_o,
    .ext_gnt_i, .ext_rvalid_i, .ext_rdata_i,
    .ram_req_o    (ram_req),    .ram_we_o    (ram_we),
    .ram_addr_o   (ram_addr),   .ram_be_o    (ram_be),
    .ram_wdata_o  (ram_wdata),  .ram_gnt_i   (ram_gnt),
    .ram_rvalid_i (ram_rvalid), .ram_rdata_i (ram_rdata)
  );

  ram_port_arbiter arb0 (
    .clk, .rst_n,
    .load_req_i, .load_we_i, .load_addr_i, .load_be_i, .load_wdata_i, .load_rdata_o,
    .core_req_i   (ram_req),    .core_we_i    (ram_we),
    .core_addr_i  (ram_addr),   .core_be_i    (ram_be),
    .core_wdata_i (ram_wdata),  .core_gnt_o   (ram_gnt),
    .core_rvalid_o(ram_rvalid), .core_rdata_o (ram_rdata),
    .mem_en_o (en), .mem_we_o (we), .mem_addr_o (addr),
    .mem_be_o (be), .mem_wdata_o (wdata), .mem_rdata_i (rdata)
  );

  data_ram ram0 (
    .clk, .en_i (en), .we_i (we), .addr_i (addr),
    .be_i (be), .wdata_i (wdata), .rdata_o (rdata)
  );

  irq_encoder irq0 (.irq_i, .irq_req_o, .irq_id_o);

endmodule : core_region

`default_nettype wire

/* source/lsu_router.sv */
// Address decoder and response router for the load/store port.
// Local-window requests go to the RAM arbiter, all others to the external bus.

`timescale 1ns/1ps
`default_nettype none

module lsu_router
  import region_pkg::*;
  import bus_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire logic      lsu_req_i,
  input  wire logic      lsu_we_i,
  input  wire lsu_addr_t lsu_addr_i,
  input  wire lsu_be_t   lsu_be_i,
  input  wire lsu_data_t lsu_wdata_i,
  output logic           lsu_gnt_o,
  output logic           lsu_rvalid_o,
  output lsu_data_t      lsu_rdata_o,
  output logic           ext_req_o,
  output logic           ext_we_o,
  output lsu_addr_t      ext_addr_o,
  output lsu_be_t        ext_be_o,
  output lsu_data_t      ext_wdata_o,
  input  wire logic      ext_gnt_i,
  input  wire logic      ext_rvalid_i,
  input  wire lsu_data_t ext_rdata_i,
  output logic           ram_req_o,
  output logic           ram_we_o,
  output lsu_addr_t      ram_addr_o,
  output lsu_be_t        ram_be_o,
  output lsu_data_t      ram_wdata_o,
  input  wire logic      ram_gnt_i,
  input  wire logic      ram_rvalid_i,
  input  wire lsu_data_t ram_rdata_i
);

  logic      is_local;
  resp_src_e resp_src_q;

  assign is_local = (lsu_addr_i[31:REGION_TAG_LSB] == LOCAL_REGION_TAG);

  // request fields fan out to both sides and only one req is raised
  assign ram_req_o   = lsu_req_i & is_local;
  assign ram_we_o    = lsu_we_i;
  assign ram_addr_o  = lsu_addr_i;
  assign ram_be_o    = lsu_be_i;
  assign ram_wdata_o = lsu_wdata_i;

  assign ext_req_o   = lsu_req_i & ~is_local;
  assign ext_we_o    = lsu_we_i;
  assign ext_addr_o  = lsu_addr_i;
  assign ext_be_o    = lsu_be_i;
  assign ext_wdata_o = lsu_wdata_i;

  assign lsu_gnt_o = lsu_req_i & (is_local ? ram_gnt_i : ext_gnt_i);

  // remember where the granted request went
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      resp_src_q <= RESP_RAM;
    end else if (lsu_gnt_o) begin
      resp_src_q <= is_local ? RESP_RAM : RESP_EXT;
    end
  end

  assign lsu_rdata_o  = (resp_src_q == RESP_EXT) ? ext_rdata_i : ram_rdata_i;
  assign lsu_rvalid_o = ram_rvalid_i | ext_rvalid_i;

  // one request outstanding, so both sides never answer at once
  a_single_resp : assert property (
    @(posedge clk) disable iff (!rst_n) !(ram_rvalid_i && ext_rvalid_i)
  );

endmodule : lsu_router

`default_nettype wire

/* source/ram_port_arbiter.sv */
// Shares the 64-bit data RAM between the loader port and the 32-bit core port.
// The loader has fixed priority; core accesses are steered into one half.

`timescale 1ns/1ps
`default_nettype none

module ram_port_arbiter
  import region_pkg::*;
  import bus_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic       load_req_i,
  input  wire logic       load_we_i,
  input  wire ram_addr_t  load_addr_i,
  input  wire wide_be_t   load_be_i,
  input  wire wide_data_t load_wdata_i,
  output wide_data_t      load_rdata_o,
  input  wire logic       core_req_i,
  input  wire logic       core_we_i,
  input  wire lsu_addr_t  core_addr_i,
  input  wire lsu_be_t    core_be_i,
  input  wire lsu_data_t  core_wdata_i,
  output logic            core_gnt_o,
  output logic            core_rvalid_o,
  output lsu_data_t       core_rdata_o,
  output logic            mem_en_o,
  output logic            mem_we_o,
  output ram_addr_t       mem_addr_o,
  output wide_be_t        mem_be_o,
  output wide_data_t      mem_wdata_o,
  input  wire wide_data_t mem_rdata_i
);

  logic      upper_half;
  logic      half_q;
  logic      core_rvalid_q;
  ram_addr_t core_word_addr;
  wide_be_t  core_wide_be;

  assign upper_half     = core_addr_i[2];
  assign core_word_addr =
    core_addr_i[RAM_ADDR_W + $clog2(RAM_WORD_BYTES) - 1 : $clog2(RAM_WORD_BYTES)];
  assign core_wide_be   = upper_half ? {core_be_i, 4'b0000} : {4'b0000, core_be_i};

  // loader always wins the port
  assign core_gnt_o = core_req_i & ~load_req_i;

  assign mem_en_o    = load_req_i | core_req_i;
  assign mem_we_o    = load_req_i ? load_we_i    : core_we_i;
  assign mem_addr_o  = load_req_i ? load_addr_i  : core_word_addr;
  assign mem_be_o    = load_req_i ? load_be_i    : core_wide_be;
  // byte enables pick the half, so the word goes to both
  assign mem_wdata_o = load_req_i ? load_wdata_i : {core_wdata_i, core_wdata_i};

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      core_rvalid_q <= 1'b0;
    end else begin
      core_rvalid_q <= core_gnt_o;
    end
  end

  always_ff @(posedge clk) begin
    if (core_gnt_o) begin
      half_q <= upper_half;
    end
  end

  assign core_rvalid_o = core_rvalid_q;
  assign core_rdata_o  = half_q ? mem_rdata_i[63:32] : mem_rdata_i[31:0];
  assign load_rdata_o  = mem_rdata_i;

  // a core request held off by the loader stays up with the same address
  a_core_hold : assert property (
    @(posedge clk) disable iff (!rst_n)
      core_req_i && !core_gnt_o |=> core_req_i && $stable(core_addr_i)
  );

endmodule : ram_port_arbiter

`default_nettype wire

/* source/irq_encoder.sv */
// Encodes the interrupt lines into a request flag and the highest active index.

`timescale 1ns/1ps
`default_nettype none

module irq_encoder
  import bus_pkg::*;
(
  input  wire irq_vec_t irq_i,
  output logic          irq_req_o,
  output irq_id_t       irq_id_o
);

  assign irq_req_o = |irq_i;

  // later lines overwrite earlier ones, so the top index wins
  always_comb begin
    irq_id_o = '0;
    for (int i = 0; i < $bits(irq_vec_t); i++) begin
      if (irq_i[i]) begin
        irq_id_o = irq_id_t'(i);
      end
    end
  end

endmodule : irq_encoder

`default_nettype wire

/* source/data_ram.sv */
// Single-port data memory with byte enables and a registered read port.
// A write returns the previous word on rdata_o.

`timescale 1ns/1ps
`default_nettype none

module data_ram
  import region_pkg::*;
  import bus_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       en_i,
  input  wire logic       we_i,
  input  wire ram_addr_t  addr_i,
  input  wire wide_be_t   be_i,
  input  wire wide_data_t wdata_i,
  output wide_data_t      rdata_o
);

  wide_data_t mem [DATA_RAM_BYTES / RAM_WORD_BYTES];

  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        // byte-masked write
        for (int i = 0; i < RAM_WORD_BYTES; i++) begin
          if (be_i[i]) begin
            mem[addr_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
          end
        end
      end
      rdata_o <= mem[addr_i];
    end
  end

endmodule : data_ram

`default_nettype wire

/* source/bus_pkg.sv */
// Bus and interrupt types shared by the core region blocks.
// Covers the 32-bit load/store port, the 64-bit loader port and the irq vector.

`default_nettype none

package bus_pkg;

  // load/store port
  typedef logic [31:0] lsu_addr_t;
  typedef logic [31:0] lsu_data_t;
  typedef logic [3:0]  lsu_be_t;

  // wide RAM and loader port
  typedef logic [63:0] wide_data_t;
  typedef logic [7:0]  wide_be_t;

  // interrupts
  typedef logic [31:0] irq_vec_t;
  typedef logic [4:0]  irq_id_t;

  // which side answers the outstanding request
  typedef enum logic [0:0] {
    RESP_RAM = 1'b0,
    RESP_EXT = 1'b1
  } resp_src_e;

endpackage : bus_pkg

`default_nettype wire

/* source/region_pkg.sv */
// Memory map and data RAM geometry of the core region.
// Imported by the router, the RAM arbiter, the RAM and the top level.

`default_nettype none

package region_pkg;

  // upper address bits that mark the local data window
  localparam logic [11:0] LOCAL_REGION_TAG = 12'h001;

  // lowest bit of the region tag in a byte address
  localparam int REGION_TAG_LSB = 20;

  // data RAM size in bytes
  localparam int DATA_RAM_BYTES = 4096;

  // one RAM word is 64 bits wide
  localparam int RAM_WORD_BYTES = 8;

  // word address width into the RAM
  localparam int RAM_ADDR_W = $clog2(DATA_RAM_BYTES / RAM_WORD_BYTES);

  typedef logic [RAM_ADDR_W-1:0] ram_addr_t;

endpackage : region_pkg

`default_nettype wire
